// ==== hdl/msx_video_pkg.sv ====
////////////////////////////////////////
// MSX video package
// Frame timing, TMS palette, register map
// and the OSD status word layout
////////////////////////////////////////

package msx_video_pkg;

	////////////////////////////////////////
	// Frame timing of the video chip
	localparam logic [8:0] H_TOTAL      = 9'd342;
	localparam logic [8:0] H_BORDER     = 9'd8;
	localparam logic [8:0] H_IMAGE      = 9'd256;
	localparam logic [8:0] H_SYNC_START = 9'd290;
	localparam logic [8:0] H_SYNC_LEN   = 9'd26;

	localparam logic [8:0] V_TOTAL      = 9'd262;
	localparam logic [8:0] V_BORDER     = 9'd8;
	localparam logic [8:0] V_IMAGE      = 9'd192;
	localparam logic [8:0] V_SYNC_START = 9'd230;
	localparam logic [8:0] V_SYNC_LEN   = 9'd3;

	////////////////////////////////////////
	// TMS palette, 24-bit RGB, colour 0 is transparent
	localparam logic [23:0] MSX_PALETTE [0:15] = '{
		24'h000000, 24'h000000, 24'h21c842, 24'h5edc78,
		24'h5455ed, 24'h7d76fc, 24'hd4524d, 24'h42ebf5,
		24'hfc5554, 24'hff7978, 24'hd4c154, 24'he6ce80,
		24'h21b03b, 24'hc95bba, 24'hcccccc, 24'hffffff
	};

	// APB register map, anything else errors
	localparam logic [3:0] ADDR_STATUS = 4'h0;
	localparam logic [3:0] ADDR_BORDER = 4'h4;

	// Crop height for 1080p output
	localparam logic [9:0] CROP_216 = 10'd216;

	////////////////////////////////////////
	// OSD status word, bit 0 first from the bottom
	typedef struct packed {
		logic [19:0] reserved_hi;
		logic [1:0]  scale_mode;
		logic [2:0]  sd_fx;
		logic [2:0]  reserved_lo;
		logic        border_en;
		logic [1:0]  aspect;
		logic        soft_reset;
	} msx_status_fields_t;

	// Same word seen raw by the bus, decoded by the video side
	typedef union packed {
		logic [31:0]        raw;
		msx_status_fields_t fields;
	} msx_status_u;

endpackage

// ==== hdl/video_if.sv ====
////////////////////////////////////////
// Raw video bundle
// Timing generator to output stage
////////////////////////////////////////

`timescale 1ns/1ps

interface video_if;

	// Pixel colour
	logic [7:0] r;
	logic [7:0] g;
	logic [7:0] b;

	// Active-low syncs and blanking, all dot-aligned
	logic hsync_n;
	logic vsync_n;
	logic hblank;
	logic vblank;

	// Video chip side
	modport src (
		output r, g, b, hsync_n, vsync_n, hblank, vblank
	);

	// Output stage side
	modport snk (
		input r, g, b, hsync_n, vsync_n, hblank, vblank
	);

endinterface

// ==== hdl/osd_status_apb.sv ====
////////////////////////////////////////
// OSD status APB slave
// Holds the status word and border colour
// written by software over APB
////////////////////////////////////////

`timescale 1ns/1ps

module osd_status_apb (
	input  logic                      CLK_VIDEO,
	input  logic                      rst,
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  logic [3:0]                paddr,
	input  logic [31:0]               pwdata,
	output logic [31:0]               prdata,
	output logic                      pready,
	output logic                      pslverr,
	output msx_video_pkg::msx_status_u status,
	output logic [3:0]                border_color
);

	logic addr_ok;
	logic wr_en;

	// Only two registers are decoded
	assign addr_ok = (paddr == msx_video_pkg::ADDR_STATUS) ||
		(paddr == msx_video_pkg::ADDR_BORDER);

	// Write lands at the end of the access phase
	assign wr_en = psel && penable && pwrite && addr_ok;

	// No wait states
	assign pready = 1'b1;

	// Error only in the access phase
	assign pslverr = psel && penable && !addr_ok;

	////////////////////////////////////////
	// Register storage
	always_ff @(posedge CLK_VIDEO) begin
		if (rst) begin
			status.raw   <= '0;
			border_color <= '0;
		end else if (wr_en) begin
			if (paddr == msx_video_pkg::ADDR_STATUS) begin
				status.raw <= pwdata;
			end else begin
				// Border keeps its low nibble only
				border_color <= pwdata[3:0];
			end
		end
	end

	////////////////////////////////////////
	// Read mux, combinational so data is ready in the access phase
	always_comb begin
		prdata = '0;
		if (psel && !pwrite) begin
			case (paddr)
				msx_video_pkg::ADDR_STATUS: prdata = status.raw;
				msx_video_pkg::ADDR_BORDER: prdata = {28'd0, border_color};
				default: prdata = '0;
			endcase
		end
	end

endmodule

// ==== hdl/pixel_ce_gen.sv ====
////////////////////////////////////////
// Dot clock enable divider
// 10.7 MHz and 5.3 MHz enables from CLK_VIDEO
////////////////////////////////////////

`timescale 1ns/1ps

module pixel_ce_gen (
	input  logic CLK_VIDEO,
	input  logic rst,
	output logic ce_10m7,
	output logic ce_pix
);

	// Free-running divide by 8
	logic [2:0] div;

	always_ff @(posedge CLK_VIDEO) begin
		if (rst) begin
			div     <= '0;
			ce_10m7 <= 1'b0;
			ce_pix  <= 1'b0;
		end else begin
			div <= div + 3'd1;
			// Pulse on the last count of each window
			// so the first enables land on cycles 4 and 8
			ce_10m7 <= (div[1:0] == 2'd3);
			ce_pix  <= (div == 3'd7);
		end
	end

endmodule

// ==== hdl/tms_timing_gen.sv ====
////////////////////////////////////////
// Display timing generator
// 342x262 frame, colour bar image, border,
// active-low syncs and blanking
////////////////////////////////////////

`timescale 1ns/1ps

module tms_timing_gen (
	input  logic       CLK_VIDEO,
	input  logic       rst,
	input  logic       ce_pix,
	input  logic       border_en,
	input  logic [3:0] border_color,
	video_if.src       vid
);

	logic [8:0]  h_cnt;
	logic [8:0]  v_cnt;
	logic        h_img;
	logic        v_img;
	logic        h_act;
	logic        v_act;
	logic        h_sync;
	logic        v_sync;
	logic [3:0]  bar;
	logic [23:0] pixel;

	////////////////////////////////////////
	// Dot and line counters
	always_ff @(posedge CLK_VIDEO) begin
		if (rst) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (ce_pix) begin
			if (h_cnt == msx_video_pkg::H_TOTAL - 9'd1) begin
				h_cnt <= '0;
				// End of line, step the line counter
				if (v_cnt == msx_video_pkg::V_TOTAL - 9'd1) begin
					v_cnt <= '0;
				end else begin
					v_cnt <= v_cnt + 9'd1;
				end
			end else begin
				h_cnt <= h_cnt + 9'd1;
			end
		end
	end

	////////////////////////////////////////
	// Region decode
	// Image sits after the left and top border
	assign h_img = (h_cnt >= msx_video_pkg::H_BORDER) &&
		(h_cnt < msx_video_pkg::H_BORDER + msx_video_pkg::H_IMAGE);
	assign v_img = (v_cnt >= msx_video_pkg::V_BORDER) &&
		(v_cnt < msx_video_pkg::V_BORDER + msx_video_pkg::V_IMAGE);

	// Border off blanks the border area too
	assign h_act = border_en ?
		(h_cnt < msx_video_pkg::H_BORDER + msx_video_pkg::H_IMAGE + msx_video_pkg::H_BORDER) :
		h_img;
	assign v_act = border_en ?
		(v_cnt < msx_video_pkg::V_BORDER + msx_video_pkg::V_IMAGE + msx_video_pkg::V_BORDER) :
		v_img;

	// Sync windows
	assign h_sync = (h_cnt >= msx_video_pkg::H_SYNC_START) &&
		(h_cnt < msx_video_pkg::H_SYNC_START + msx_video_pkg::H_SYNC_LEN);
	assign v_sync = (v_cnt >= msx_video_pkg::V_SYNC_START) &&
		(v_cnt < msx_video_pkg::V_SYNC_START + msx_video_pkg::V_SYNC_LEN);

	// Sixteen bars of 16 dots each across the image
	assign bar = 4'((h_cnt - msx_video_pkg::H_BORDER) >> 4);

	// Outside the image the border colour is shown
	assign pixel = (h_img && v_img) ? msx_video_pkg::MSX_PALETTE[bar] :
		msx_video_pkg::MSX_PALETTE[border_color];

	////////////////////////////////////////
	// Registered outputs, one update per dot
	always_ff @(posedge CLK_VIDEO) begin
		if (rst) begin
			vid.hsync_n <= 1'b1;
			vid.vsync_n <= 1'b1;
			vid.hblank  <= 1'b1;
			vid.vblank  <= 1'b1;
		end else if (ce_pix) begin
			vid.hsync_n <= ~h_sync;
			vid.vsync_n <= ~v_sync;
			vid.hblank  <= ~h_act;
			vid.vblank  <= ~v_act;
		end
	end

	// Pixel colour
	always_ff @(posedge CLK_VIDEO) begin
		if (ce_pix) begin
			{vid.r, vid.g, vid.b} <= pixel;
		end
	end

endmodule

// ==== hdl/video_out_align.sv ====
////////////////////////////////////////
// Video output stage
// Positive syncs, vsync aligned to hsync,
// display enable and pixel register
////////////////////////////////////////

`timescale 1ns/1ps

module video_out_align (
	input  logic       CLK_VIDEO,
	input  logic       rst,
	input  logic       ce_pix,
	video_if.snk       vid,
	output logic [7:0] vga_r,
	output logic [7:0] vga_g,
	output logic [7:0] vga_b,
	output logic       vga_hs,
	output logic       vga_vs,
	output logic       vga_de
);

	// Source updates on the ce edge, sample on the cycle after
	logic ce_q;
	logic de_in;

	assign de_in = ~(vid.hblank | vid.vblank);

	always_ff @(posedge CLK_VIDEO) begin
		if (rst) begin
			ce_q   <= 1'b0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
			vga_de <= 1'b0;
		end else begin
			ce_q <= ce_pix;
			if (ce_q) begin
				vga_hs <= ~vid.hsync_n;
				// Vsync moves only at the leading edge of hsync
				if (!vga_hs && !vid.hsync_n) begin
					vga_vs <= ~vid.vsync_n;
				end
				vga_de <= de_in;
			end
		end
	end

	// Blanked dots go out black
	always_ff @(posedge CLK_VIDEO) begin
		if (ce_q) begin
			{vga_r, vga_g, vga_b} <= de_in ? {vid.r, vid.g, vid.b} : 24'd0;
		end
	end

endmodule

// ==== hdl/scaler_ctrl.sv ====
////////////////////////////////////////
// Scaler control
// Aspect, crop, scanline and scandoubler
// words from the status word and HDMI size
////////////////////////////////////////

`timescale 1ns/1ps

module scaler_ctrl (
	input  logic                       CLK_VIDEO,
	input  logic                       rst,
	input  msx_video_pkg::msx_status_u status,
	input  logic                       forced_scandoubler,
	input  logic [11:0]                hdmi_width,
	input  logic [11:0]                hdmi_height,
	output logic [12:0]                video_arx,
	output logic [12:0]                video_ary,
	output logic [9:0]                 crop_size,
	output logic [1:0]                 vga_sl,
	output logic                       scandoubler,
	output logic                       hq2x
);

	logic [1:0] aspect;
	logic [2:0] sd_fx;
	logic [2:0] sl_dec;
	logic       en_216p;

	assign aspect = status.fields.aspect;
	assign sd_fx  = status.fields.sd_fx;

	// Scanline level counts from the first CRT option
	assign sl_dec = sd_fx - 3'd1;

	// 216 line crop only for native 1080p with no doubler
	assign en_216p = (hdmi_width == 12'd1920) && (hdmi_height == 12'd1080) &&
		!forced_scandoubler && (sd_fx == 3'd0);

	////////////////////////////////////////
	// Registered outputs
	always_ff @(posedge CLK_VIDEO) begin
		if (rst) begin
			// 4:3 matches a cleared status word
			video_arx   <= 13'd4;
			video_ary   <= 13'd3;
			crop_size   <= '0;
			vga_sl      <= '0;
			scandoubler <= 1'b0;
			hq2x        <= 1'b0;
		end else begin
			// Aspect 0 is original 4:3, others select full or custom ratio
			if (aspect == 2'd0) begin
				video_arx <= 13'd4;
				video_ary <= 13'd3;
			end else begin
				video_arx <= {11'd0, 2'(aspect - 2'd1)};
				video_ary <= 13'd0;
			end
			crop_size   <= en_216p ? msx_video_pkg::CROP_216 : 10'd0;
			vga_sl      <= (sd_fx != 3'd0) ? sl_dec[1:0] : 2'd0;
			scandoubler <= (sd_fx != 3'd0) || forced_scandoubler;
			// First effect option is HQ2x
			hq2x        <= (sd_fx == 3'd1);
		end
	end

endmodule

// ==== hdl/msx_video_top.sv ====
////////////////////////////////////////
// MSX video subsystem top
// APB options, dot enables, timing,
// output stage and scaler control
////////////////////////////////////////

`timescale 1ns/1ps

module msx_video_top (
	input  logic        CLK_VIDEO,
	input  logic        rst,
	// APB host port
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [3:0]  paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr,
	// HDMI side information
	input  logic        forced_scandoubler,
	input  logic [11:0] hdmi_width,
	input  logic [11:0] hdmi_height,
	// Video out
	output logic        ce_pixel,
	output logic [7:0]  vga_r,
	output logic [7:0]  vga_g,
	output logic [7:0]  vga_b,
	output logic        vga_hs,
	output logic        vga_vs,
	output logic        vga_de,
	// Scaler control words
	output logic [12:0] video_arx,
	output logic [12:0] video_ary,
	output logic [9:0]  crop_size,
	output logic [1:0]  vga_sl,
	output logic        scandoubler,
	output logic        hq2x
);

	msx_video_pkg::msx_status_u status;
	logic [3:0] border_color;
	logic       ce_pix;
	logic       core_rst;

	video_if vid ();

	// Soft reset from the OSD holds the video core
	assign core_rst = rst | status.fields.soft_reset;
	assign ce_pixel = ce_pix;

	osd_status_apb u_osd_status_apb (
		.CLK_VIDEO    (CLK_VIDEO),
		.rst          (rst),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr),
		.status       (status),
		.border_color (border_color)
	);

	// CPU enable has no consumer in this subsystem
	pixel_ce_gen u_pixel_ce_gen (
		.CLK_VIDEO (CLK_VIDEO),
		.rst       (rst),
		.ce_10m7   (),
		.ce_pix    (ce_pix)
	);

	tms_timing_gen u_tms_timing_gen (
		.CLK_VIDEO    (CLK_VIDEO),
		.rst          (core_rst),
		.ce_pix       (ce_pix),
		.border_en    (status.fields.border_en),
		.border_color (border_color),
		.vid          (vid.src)
	);

	video_out_align u_video_out_align (
		.CLK_VIDEO (CLK_VIDEO),
		.rst       (core_rst),
		.ce_pix    (ce_pix),
		.vid       (vid.snk),
		.vga_r     (vga_r),
		.vga_g     (vga_g),
		.vga_b     (vga_b),
		.vga_hs    (vga_hs),
		.vga_vs    (vga_vs),
		.vga_de    (vga_de)
	);

	scaler_ctrl u_scaler_ctrl (
		.CLK_VIDEO          (CLK_VIDEO),
		.rst                (rst),
		.status             (status),
		.forced_scandoubler (forced_scandoubler),
		.hdmi_width         (hdmi_width),
		.hdmi_height        (hdmi_height),
		.video_arx          (video_arx),
		.video_ary          (video_ary),
		.crop_size          (crop_size),
		.vga_sl             (vga_sl),
		.scandoubler        (scandoubler),
		.hq2x               (hq2x)
	);

endmodule

// ==== tb/msx_video_asserts.sv ====
////////////////////////////////////////
// Bound checks for the video subsystem
// Sync alignment, APB ready and dot rate
////////////////////////////////////////

`timescale 1ns/1ps

module msx_video_asserts (
	input logic CLK_VIDEO,
	input logic rst,
	input logic core_rst,
	input logic vga_hs,
	input logic vga_vs,
	input logic pready,
	input logic ce_pix
);

	// Cycles since the last dot enable
	int unsigned gap;
	logic        seen;

	always_ff @(posedge CLK_VIDEO) begin
		if (rst) begin
			gap  <= 0;
			seen <= 1'b0;
		end else if (ce_pix) begin
			gap  <= 0;
			seen <= 1'b1;
		end else begin
			gap <= gap + 1;
		end
	end

	// Vsync only moves together with the hsync leading edge
	vs_on_hs_rise: assert property (@(posedge CLK_VIDEO) disable iff (core_rst)
		$changed(vga_vs) |-> $rose(vga_hs))
		else $error("vga_vs changed away from an hsync rising edge");

	// No wait states on the bus
	ready_high: assert property (@(posedge CLK_VIDEO) disable iff (rst) pready)
		else $error("pready went low");

	// At least 7 idle cycles between dot enables
	ce_spacing: assert property (@(posedge CLK_VIDEO) disable iff (rst)
		(ce_pix && seen) |-> (gap >= 7))
		else $error("ce_pix came too early");

endmodule

bind msx_video_top msx_video_asserts u_asserts (
	.CLK_VIDEO (CLK_VIDEO),
	.rst       (rst),
	.core_rst  (core_rst),
	.vga_hs    (vga_hs),
	.vga_vs    (vga_vs),
	.pready    (pready),
	.ce_pix    (ce_pix)
);

// ==== tb/msx_video_tb.sv ====
////////////////////////////////////////
// Testbench for the MSX video subsystem
// APB, scaler words, sync and frame checks
////////////////////////////////////////

`timescale 1ns/1ps

module msx_video_tb;

	logic        CLK_VIDEO;
	logic        rst;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [3:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        forced_scandoubler;
	logic [11:0] hdmi_width;
	logic [11:0] hdmi_height;
	logic        ce_pixel;
	logic [7:0]  vga_r;
	logic [7:0]  vga_g;
	logic [7:0]  vga_b;
	logic        vga_hs;
	logic        vga_vs;
	logic        vga_de;
	logic [12:0] video_arx;
	logic [12:0] video_ary;
	logic [9:0]  crop_size;
	logic [1:0]  vga_sl;
	logic        scandoubler;
	logic        hq2x;

	int          value_errors;
	int          other_errors;
	logic [31:0] rng;

	msx_video_top DUT (.*);

	////////////////////////////////////////
	// Clock, reset and watchdog
	initial begin
		CLK_VIDEO = 1'b0;
		forever #50 CLK_VIDEO = ~CLK_VIDEO;
	end

	// Five frames of dots plus room for the bus tests
	initial begin
		#(longint'(5 * 342 * 262 * 8 + 2000) * 100);
		$display("Watchdog expired before the tests finished");
		$display("Test failed");
		$finish;
	end

	////////////////////////////////////////
	// Random numbers and reference models
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [12:0] ref_arx(input logic [1:0] aspect);
		return (aspect == 2'd0) ? 13'd4 : {11'd0, aspect - 2'd1};
	endfunction

	function automatic logic [12:0] ref_ary(input logic [1:0] aspect);
		return (aspect == 2'd0) ? 13'd3 : 13'd0;
	endfunction

	function automatic logic [1:0] ref_sl(input logic [2:0] sd_fx);
		logic [2:0] lvl;
		lvl = sd_fx - 3'd1;
		return (sd_fx == 3'd0) ? 2'd0 : lvl[1:0];
	endfunction

	function automatic logic [9:0] ref_crop(input logic [11:0] w, input logic [11:0] h,
		input logic forced, input logic [2:0] sd_fx);
		if (w == 12'd1920 && h == 12'd1080 && !forced && sd_fx == 3'd0) begin
			return 10'd216;
		end
		return 10'd0;
	endfunction

	// Colour of de pixel k on de line n
	function automatic logic [23:0] expected_pixel(input int k, input int n,
		input logic border, input logic [3:0] color);
		if (!border) begin
			return msx_video_pkg::MSX_PALETTE[4'(k / 16)];
		end
		if (n < 8 || n >= 200 || k < 8 || k >= 264) begin
			return msx_video_pkg::MSX_PALETTE[color];
		end
		return msx_video_pkg::MSX_PALETTE[4'((k - 8) / 16)];
	endfunction

	////////////////////////////////////////
	// Compare tasks
	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("FAIL %s expected %h actual %h", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_rgb(input string name, input logic [23:0] exp, input logic [23:0] act);
		if (exp !== act) begin
			$display("FAIL %s expected %h actual %h", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (exp != act) begin
			$display("FAIL %s expected %0d actual %0d", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_status(input string name, input msx_video_pkg::msx_status_u exp,
		input msx_video_pkg::msx_status_u act);
		if (exp.fields !== act.fields) begin
			$display("FAIL %s expected %h actual %h", name, exp.raw, act.raw);
			value_errors++;
		end
	endtask

	////////////////////////////////////////
	// APB driver, sampled in the access phase
	task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] data,
		output logic [31:0] rdata, output logic err);
		@(posedge CLK_VIDEO);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge CLK_VIDEO);
		penable <= 1'b1;
		@(negedge CLK_VIDEO);
		rdata = prdata;
		err   = pslverr;
		@(posedge CLK_VIDEO);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
		logic [31:0] rd;
		logic        err;
		apb_access(1'b1, addr, data, rd, err);
		check_word("apb write pslverr", 32'd0, {31'd0, err});
	endtask

	// Next mid-cycle point that has a dot enable
	task automatic next_dot();
		do begin
			@(negedge CLK_VIDEO);
		end while (!ce_pixel);
	endtask

	////////////////////////////////////////
	// Frame checker, runs from one vsync rise to the next
	task automatic check_frame(input string name, input logic wait_sync,
		input logic border, input logic [3:0] color);
		logic prev_hs;
		logic prev_vs;
		logic prev_de;
		int   hs_rises;
		int   period;
		int   high;
		int   k;
		int   line;
		logic started;
		hs_rises = 0;
		period   = 0;
		high     = 0;
		k        = 0;
		line     = 0;
		started  = 1'b0;
		@(negedge CLK_VIDEO);
		prev_hs = vga_hs;
		prev_vs = vga_vs;
		prev_de = vga_de;
		// Skip to the start of a frame
		if (wait_sync) begin
			do begin
				prev_vs = vga_vs;
				next_dot();
			end while (!(vga_vs && !prev_vs));
			prev_hs = vga_hs;
			prev_vs = vga_vs;
			prev_de = vga_de;
		end
		forever begin
			next_dot();
			period++;
			// Line period and sync width
			if (vga_hs && !prev_hs) begin
				if (started) begin
					check_count({name, " hs period"}, int'(msx_video_pkg::H_TOTAL), period);
				end
				started = 1'b1;
				period  = 0;
				high    = 0;
				hs_rises++;
			end
			if (vga_hs) begin
				high++;
			end
			if (!vga_hs && prev_hs && started) begin
				check_count({name, " hs width"}, int'(msx_video_pkg::H_SYNC_LEN), high);
			end
			// Active pixels
			if (vga_de) begin
				check_rgb({name, " pixel"}, expected_pixel(k, line, border, color),
					{vga_r, vga_g, vga_b});
				k++;
			end
			if (!vga_de && prev_de) begin
				check_count({name, " de pixels"}, border ? 272 : 256, k);
				line++;
				k = 0;
			end
			if (vga_vs && !prev_vs) begin
				break;
			end
			prev_hs = vga_hs;
			prev_vs = vga_vs;
			prev_de = vga_de;
		end
		check_count({name, " lines"}, int'(msx_video_pkg::V_TOTAL), hs_rises);
		check_count({name, " de lines"}, border ? 208 : 192, line);
	endtask

	////////////////////////////////////////
	// Test sequence
	initial begin
		msx_video_pkg::msx_status_u st;
		msx_video_pkg::msx_status_u rd_st;
		logic [31:0] rd;
		logic        err;
		logic [3:0]  color;
		int          fails;
		value_errors       = 0;
		other_errors       = 0;
		rng                = 32'h899d;
		rst                = 1'b1;
		psel               = 1'b0;
		penable            = 1'b0;
		pwrite             = 1'b0;
		paddr              = 4'h0;
		pwdata             = 32'd0;
		forced_scandoubler = 1'b0;
		hdmi_width         = 12'd1920;
		hdmi_height        = 12'd1080;
		repeat (3) @(posedge CLK_VIDEO);
		rst <= 1'b0;

		// APB readback with random data
		for (int i = 0; i < 4; i++) begin
			rng = xorshift(rng);
			write_reg(msx_video_pkg::ADDR_STATUS, rng);
			apb_access(1'b0, msx_video_pkg::ADDR_STATUS, 32'd0, rd, err);
			st.raw    = rng;
			rd_st.raw = rd;
			check_status("apb status", st, rd_st);
			rng = xorshift(rng);
			write_reg(msx_video_pkg::ADDR_BORDER, rng);
			apb_access(1'b0, msx_video_pkg::ADDR_BORDER, 32'd0, rd, err);
			check_word("apb border", {28'd0, rng[3:0]}, rd);
		end
		apb_access(1'b1, 4'h8, 32'hffff_ffff, rd, err);
		check_word("apb bad write pslverr", 32'd1, {31'd0, err});
		apb_access(1'b0, 4'hc, 32'd0, rd, err);
		check_word("apb bad read pslverr", 32'd1, {31'd0, err});
		write_reg(msx_video_pkg::ADDR_BORDER, 32'd0);

		// Scaler words over every aspect, effect and forced setting
		for (int a = 0; a < 4; a++) begin
			for (int fx = 0; fx < 8; fx++) begin
				for (int f = 0; f < 2; f++) begin
					st.raw           = 32'd0;
					st.fields.aspect = 2'(a);
					st.fields.sd_fx  = 3'(fx);
					write_reg(msx_video_pkg::ADDR_STATUS, st.raw);
					@(posedge CLK_VIDEO);
					forced_scandoubler <= 1'(f);
					repeat (2) @(posedge CLK_VIDEO);
					@(negedge CLK_VIDEO);
					check_word("scaler arx", {19'd0, ref_arx(2'(a))}, {19'd0, video_arx});
					check_word("scaler ary", {19'd0, ref_ary(2'(a))}, {19'd0, video_ary});
					check_word("scaler sl", {30'd0, ref_sl(3'(fx))}, {30'd0, vga_sl});
					check_word("scaler crop",
						{22'd0, ref_crop(hdmi_width, hdmi_height, 1'(f), 3'(fx))},
						{22'd0, crop_size});
					check_word("scaler sd", {31'd0, (fx != 0) || (f != 0)},
						{31'd0, scandoubler});
					check_word("scaler hq2x", {31'd0, fx == 1}, {31'd0, hq2x});
				end
			end
		end
		// No crop away from 1080p
		write_reg(msx_video_pkg::ADDR_STATUS, 32'd0);
		@(posedge CLK_VIDEO);
		forced_scandoubler <= 1'b0;
		hdmi_width         <= 12'd1280;
		hdmi_height        <= 12'd720;
		repeat (2) @(posedge CLK_VIDEO);
		@(negedge CLK_VIDEO);
		check_word("scaler crop 720p", 32'd0, {22'd0, crop_size});

		// Border off, then border on straight after the frame edge
		check_frame("border off", 1'b1, 1'b0, 4'd0);
		rng   = xorshift(rng);
		color = rng[3:0];
		write_reg(msx_video_pkg::ADDR_BORDER, {28'd0, color});
		st.raw              = 32'd0;
		st.fields.border_en = 1'b1;
		write_reg(msx_video_pkg::ADDR_STATUS, st.raw);
		check_frame("border on", 1'b0, 1'b1, color);

		// Soft reset holds the video for a line
		st.raw               = 32'd0;
		st.fields.soft_reset = 1'b1;
		write_reg(msx_video_pkg::ADDR_STATUS, st.raw);
		// Output registers clear on the edge after the bit lands
		@(posedge CLK_VIDEO);
		fails = 0;
		repeat (int'(msx_video_pkg::H_TOTAL) * 8) begin
			@(negedge CLK_VIDEO);
			if (vga_hs || vga_de) begin
				fails++;
			end
		end
		if (fails != 0) begin
			$display("Soft reset did not hold hsync and de low for a line");
			other_errors++;
		end
		write_reg(msx_video_pkg::ADDR_STATUS, 32'd0);
		check_frame("after soft reset", 1'b1, 1'b0, color);

		$display("Errors: %0d value, %0d other", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== all.f ====
hdl/msx_video_pkg.sv
hdl/video_if.sv
hdl/osd_status_apb.sv
hdl/pixel_ce_gen.sv
hdl/tms_timing_gen.sv
hdl/video_out_align.sv
hdl/scaler_ctrl.sv
hdl/msx_video_top.sv
tb/msx_video_asserts.sv
tb/msx_video_tb.sv

// ==== run.sh ====
#!/bin/bash
# Build and run the video subsystem simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module msx_video_tb -o msx_video_sim
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

out=$(./obj_dir/msx_video_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test completed successfully" <<< "$out"; then
	exit 0
fi
exit 1
